// File: vlog.f
+incdir+include
logic/rv_pred_pkg.sv
logic/rv_resolve_decode.sv
logic/rv_btb.sv
logic/rv_ras.sv
logic/rv_fetch_predictor.sv
tb/rv_fetch_predictor_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the predictor and its testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal -f vlog.f \
  --top-module rv_fetch_predictor_tb -o rv_fetch_predictor_sim > build.log 2>&1 \
  && ./obj_dir/rv_fetch_predictor_sim > sim.log 2>&1 \
  || { cat build.log; echo "Build or simulation step failed"; }

[ -f sim.log ] && cat sim.log

grep -qx "Done: no errors" sim.log 2>/dev/null \
  && echo "Simulation passed" \
  && exit 0

echo "Simulation failed"
exit 1

// File: tb/rv_fetch_predictor_tb.sv
`timescale 1ns/10ps

`include "rv_pred_config.svh"

module rv_fetch_predictor_tb;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  localparam logic [15:0] LFSR_SEED = 16'd56898;

  // Fixed PCs of the scenarios are chosen so that their BTB indices differ where it matters
  localparam logic [`RV_XLEN-1:0] RET_PC = 32'h0000_030C;
  localparam logic [`RV_XLEN-1:0] BR_PC  = 32'h0000_0520;
  localparam logic [`RV_XLEN-1:0] BR_TGT = 32'h0000_0600;

  // One table row holds everything but the name, which lives in a parallel queue
  typedef struct packed {
    rv_pred_pkg::resolve_t    res;
    logic [`RV_XLEN-1:0]      fetch_pc;
    logic                     same_cycle;
    rv_pred_pkg::fetch_pred_t exp;
  } row_t;

  logic                     clk;
  logic                     rst_n;
  logic [`RV_XLEN-1:0]      fetch_pc;
  rv_pred_pkg::resolve_t    resolve;
  rv_pred_pkg::fetch_pred_t pred;

  row_t        rows  [$];
  string       names [$];
  logic [15:0] lfsr;
  logic        table_ready;
  int          pass_count;
  int          fail_count;

  rv_fetch_predictor rv_fetch_predictor_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .fetch_pc (fetch_pc),
    .resolve  (resolve),
    .pred     (pred)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Taps 16, 14, 13 and 11 give a maximal-length sequence
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Builds a word-aligned random PC with one LFSR step per address bit
  task automatic random_pc(output logic [`RV_XLEN-1:0] pc);
    pc = '0;
    for (int i = 0; i < `RV_XLEN - 2; i++) begin
      lfsr = lfsr_next(lfsr);
      pc = {pc[`RV_XLEN-2:0], lfsr[0]};
    end
    pc = {pc[`RV_XLEN-3:0], 2'b00};
  endtask

  function automatic rv_pred_pkg::instr_word_u jal_word(input logic [4:0] rd);
    rv_pred_pkg::instr_word_u w;
    w = '0;
    w.j_view.rd     = rd;
    w.j_view.opcode = 7'b1101111;
    return w;
  endfunction

  function automatic rv_pred_pkg::instr_word_u jalr_word(input logic [4:0] rd,
                                                         input logic [4:0] rs1);
    rv_pred_pkg::instr_word_u w;
    w = '0;
    w.i_view.rs1    = rs1;
    w.i_view.rd     = rd;
    w.i_view.opcode = 7'b1100111;
    return w;
  endfunction

  // BEQ x0, x0 is enough because only the opcode matters to the predictor
  function automatic rv_pred_pkg::instr_word_u branch_word();
    rv_pred_pkg::instr_word_u w;
    w = '0;
    w.i_view.opcode = 7'b1100011;
    return w;
  endfunction

  function automatic rv_pred_pkg::resolve_t strobe(input logic [`RV_XLEN-1:0] pc,
                                                   input rv_pred_pkg::instr_word_u instr,
                                                   input logic [`RV_XLEN-1:0] target,
                                                   input logic taken);
    rv_pred_pkg::resolve_t r;
    r.valid  = 1'b1;
    r.pc     = pc;
    r.instr  = instr;
    r.target = target;
    r.taken  = taken;
    return r;
  endfunction

  task automatic add_row(input string name, input rv_pred_pkg::resolve_t res,
                         input logic [`RV_XLEN-1:0] pc, input logic same,
                         input logic taken, input logic [`RV_XLEN-1:0] next,
                         input rv_pred_pkg::cf_kind_e kind);
    row_t r;
    r.res          = res;
    r.fetch_pc     = pc;
    r.same_cycle   = same;
    r.exp.taken    = taken;
    r.exp.next_pc  = next;
    r.exp.kind     = kind;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic build_table();
    logic [`RV_XLEN-1:0]      pc;
    logic [`RV_XLEN-1:0]      cpc;
    logic [`RV_XLEN-1:0]      ret_addr [9];
    rv_pred_pkg::instr_word_u word;
    // With a cold BTB every PC falls through
    add_row("cold_miss", '0, 32'h0000_1000, 1'b0, 1'b0, 32'h0000_1004, rv_pred_pkg::cf_none);
    for (int i = 0; i < 3; i++) begin
      random_pc(pc);
      add_row($sformatf("random_miss_%0d", i), '0, pc, 1'b0, 1'b0, pc + 32'd4,
              rv_pred_pkg::cf_none);
    end
    // A return on an empty stack installs its BTB entry with a stale target
    add_row("ret_no_stack", strobe(RET_PC, jalr_word(5'd0, 5'd1), 32'h0000_0EEC, 1'b1),
            RET_PC, 1'b0, 1'b1, 32'h0000_0EEC, rv_pred_pkg::cf_ret);
    // The return entry now sees each push in the strobe cycle itself
    add_row("call1_forward", strobe(32'h0000_0104, jal_word(5'd1), 32'h0000_0200, 1'b1),
            RET_PC, 1'b1, 1'b1, 32'h0000_0108, rv_pred_pkg::cf_ret);
    add_row("call2_forward", strobe(32'h0000_0208, jalr_word(5'd1, 5'd6), 32'h0000_0300, 1'b1),
            RET_PC, 1'b1, 1'b1, 32'h0000_020C, rv_pred_pkg::cf_ret);
    add_row("call2_btb", '0, 32'h0000_0208, 1'b0, 1'b1, 32'h0000_0300, rv_pred_pkg::cf_call);
    add_row("ret1_lifo", strobe(RET_PC, jalr_word(5'd0, 5'd1), 32'h0000_020C, 1'b1),
            RET_PC, 1'b0, 1'b1, 32'h0000_0108, rv_pred_pkg::cf_ret);
    // Stack is empty again, so the last resolved target comes from the BTB
    add_row("ret2_lifo", strobe(RET_PC, jalr_word(5'd0, 5'd1), 32'h0000_0108, 1'b1),
            RET_PC, 1'b0, 1'b1, 32'h0000_0108, rv_pred_pkg::cf_ret);
    // Nine calls go into an eight-deep stack and alternate between JAL x5 and JALR x1, x1
    for (int k = 0; k < 9; k++) begin
      cpc = 32'h0000_1000 + k * 32'h40;
      ret_addr[k] = cpc + 32'd4;
      if (k % 2 == 0) begin
        word = jal_word(5'd5);
      end else begin
        word = jalr_word(5'd1, 5'd1);
      end
      add_row($sformatf("overflow_call_%0d", k), strobe(cpc, word, 32'h0000_0800, 1'b1),
              RET_PC, 1'b0, 1'b1, ret_addr[k], rv_pred_pkg::cf_ret);
    end
    // Eight pops drain the stack and the first return address is already gone
    // so the final lookup must fall back to the BTB and not see ret_addr[0]
    for (int j = 1; j <= 8; j++) begin
      add_row($sformatf("overflow_ret_%0d", j),
              strobe(RET_PC, jalr_word(5'd0, 5'd1), ret_addr[9-j], 1'b1), RET_PC, 1'b0,
              1'b1, (j < 8) ? ret_addr[8-j] : ret_addr[1], rv_pred_pkg::cf_ret);
    end
    // Counter starts at 2, then 1, 0, 1, 2
    add_row("branch_new", strobe(BR_PC, branch_word(), BR_TGT, 1'b1), BR_PC, 1'b0,
            1'b1, BR_TGT, rv_pred_pkg::cf_branch);
    add_row("branch_not_taken_1", strobe(BR_PC, branch_word(), BR_TGT, 1'b0), BR_PC, 1'b0,
            1'b0, BR_PC + 32'd4, rv_pred_pkg::cf_branch);
    add_row("branch_not_taken_2", strobe(BR_PC, branch_word(), BR_TGT, 1'b0), BR_PC, 1'b0,
            1'b0, BR_PC + 32'd4, rv_pred_pkg::cf_branch);
    add_row("branch_taken_1", strobe(BR_PC, branch_word(), BR_TGT, 1'b1), BR_PC, 1'b0,
            1'b0, BR_PC + 32'd4, rv_pred_pkg::cf_branch);
    add_row("branch_taken_2", strobe(BR_PC, branch_word(), BR_TGT, 1'b1), BR_PC, 1'b0,
            1'b1, BR_TGT, rv_pred_pkg::cf_branch);
    add_row("branch_miss_not_taken",
            strobe(32'h0000_0564, branch_word(), 32'h0000_0700, 1'b0), 32'h0000_0564, 1'b0,
            1'b0, 32'h0000_0568, rv_pred_pkg::cf_none);
    // Two calls come first, then a coroutine swap replaces only the top
    add_row("co_call_a", strobe(32'h0000_0728, jal_word(5'd1), 32'h0000_0900, 1'b1),
            RET_PC, 1'b0, 1'b1, 32'h0000_072C, rv_pred_pkg::cf_ret);
    add_row("co_call_b", strobe(32'h0000_0740, jal_word(5'd1), 32'h0000_0920, 1'b1),
            RET_PC, 1'b0, 1'b1, 32'h0000_0744, rv_pred_pkg::cf_ret);
    add_row("coret_swap", strobe(32'h0000_0930, jalr_word(5'd5, 5'd1), 32'h0000_0744, 1'b1),
            RET_PC, 1'b0, 1'b1, 32'h0000_0934, rv_pred_pkg::cf_ret);
    add_row("coret_depth", strobe(RET_PC, jalr_word(5'd0, 5'd1), 32'h0000_0934, 1'b1),
            RET_PC, 1'b0, 1'b1, 32'h0000_072C, rv_pred_pkg::cf_ret);
    // Plain jumps leave the remaining top alone
    add_row("jalr_jump_no_ras", strobe(32'h0000_0950, jalr_word(5'd0, 5'd6), 32'h0000_0A00, 1'b1),
            RET_PC, 1'b0, 1'b1, 32'h0000_072C, rv_pred_pkg::cf_ret);
    add_row("jal_x0_no_ras", strobe(32'h0000_0964, jal_word(5'd0), 32'h0000_0B00, 1'b1),
            RET_PC, 1'b0, 1'b1, 32'h0000_072C, rv_pred_pkg::cf_ret);
    add_row("jal_x0_btb", '0, 32'h0000_0964, 1'b0, 1'b1, 32'h0000_0B00, rv_pred_pkg::cf_jump);
    add_row("coret_btb", '0, 32'h0000_0930, 1'b0, 1'b1, 32'h0000_072C, rv_pred_pkg::cf_coret);
  endtask

  task automatic check_row(input int i);
    if (pred !== rows[i].exp) begin
      fail_count++;
      $display(
        "error %s: expected taken=%0b next_pc=%h kind=%0d, actual taken=%0b next_pc=%h kind=%0d",
        names[i], rows[i].exp.taken, rows[i].exp.next_pc, rows[i].exp.kind,
        pred.taken, pred.next_pc, pred.kind);
    end else begin
      pass_count++;
      $display("ok %s: taken=%0b next_pc=%h", names[i], pred.taken, pred.next_pc);
    end
  endtask

  // Strobes for one cycle and samples mid-cycle in the strobe cycle or the one after
  task automatic run_row(input int i);
    @(posedge clk);
    #2;
    resolve  = rows[i].res;
    fetch_pc = rows[i].fetch_pc;
    if (rows[i].same_cycle) begin
      #10;
      check_row(i);
    end
    @(posedge clk);
    #2;
    resolve = '0;
    if (!rows[i].same_cycle) begin
      #10;
      check_row(i);
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    fetch_pc    = '0;
    resolve     = '0;
    pass_count  = 0;
    fail_count  = 0;
    table_ready = 1'b0;
    lfsr        = LFSR_SEED;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < rows.size(); i++) begin
      run_row(i);
    end
    $display("tests: %0d, passed: %0d, failed: %0d", rows.size(), pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Each row takes two cycles, so three cycles per row bound the whole table
  initial begin
    wait (table_ready);
    #((rows.size() * 3 + RESET_CYCLES) * CLK_PERIOD);
    $display("Timeout: the stimulus table did not finish in the expected time");
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: logic/rv_fetch_predictor.sv
`timescale 1ns/10ps

`include "rv_pred_config.svh"

module rv_fetch_predictor (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`RV_XLEN-1:0]      fetch_pc,
  input  rv_pred_pkg::resolve_t    resolve,
  output rv_pred_pkg::fetch_pred_t pred
);

  // Commands from the resolve decoder
  rv_pred_pkg::btb_update_t btb_update;
  logic                     push_en;
  logic [`RV_XLEN-1:0]      push_addr;
  logic                     pop_en;

  // Lookup results for the current fetch PC
  logic                     btb_hit;
  rv_pred_pkg::cf_kind_e    btb_kind;
  logic [`RV_XLEN-1:0]      btb_target;
  logic                     btb_taken;
  logic                     ras_valid;
  logic [`RV_XLEN-1:0]      ras_target;

  logic [`RV_XLEN-1:0]      seq_pc;

  rv_resolve_decode rv_resolve_decode_inst (
    .resolve    (resolve),
    .btb_update (btb_update),
    .push_en    (push_en),
    .push_addr  (push_addr),
    .pop_en     (pop_en)
  );

  rv_btb rv_btb_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_pc      (fetch_pc),
    .hit           (btb_hit),
    .kind          (btb_kind),
    .target        (btb_target),
    .predict_taken (btb_taken),
    .update        (btb_update)
  );

  rv_ras rv_ras_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .ras_valid  (ras_valid),
    .ras_target (ras_target),
    .push_en    (push_en),
    .push_addr  (push_addr),
    .pop_en     (pop_en)
  );

  // Fall-through address when nothing redirects fetch
  assign seq_pc = fetch_pc + `RV_XLEN'(4);

  // Pick the next PC, the whole path is combinational within the cycle
  always_comb begin
    pred.taken   = 1'b0;
    pred.next_pc = seq_pc;
    pred.kind    = btb_kind;
    if (btb_hit) begin
      case (btb_kind)
        rv_pred_pkg::cf_ret, rv_pred_pkg::cf_coret: begin
          // Returns prefer the stack, the stored target is only a fallback
          pred.taken   = 1'b1;
          pred.next_pc = ras_valid ? ras_target : btb_target;
        end
        rv_pred_pkg::cf_jump, rv_pred_pkg::cf_call: begin
          pred.taken   = 1'b1;
          pred.next_pc = btb_target;
        end
        rv_pred_pkg::cf_branch: begin
          // Conditional branches follow their counter
          pred.taken   = btb_taken;
          pred.next_pc = btb_taken ? btb_target : seq_pc;
        end
        default: begin
          // An entry of kind none is never written, treat it like a miss
        end
      endcase
    end
  end

endmodule

// File: logic/rv_ras.sv
`timescale 1ns/10ps

`include "rv_pred_config.svh"

module rv_ras #(
  parameter int DEPTH = `RV_RAS_DEPTH
) (
  input  logic                clk,
  input  logic                rst_n,
  output logic                ras_valid,
  output logic [`RV_XLEN-1:0] ras_target,
  input  logic                push_en,
  input  logic [`RV_XLEN-1:0] push_addr,
  input  logic                pop_en
);

  localparam int SP_BITS  = $clog2(DEPTH);
  // One more bit than the pointer so a full stack can be told from an empty one
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  // Return addresses, SP always names the current top
  logic [`RV_XLEN-1:0] stack [DEPTH];
  logic [SP_BITS-1:0]  sp;
  logic [CNT_BITS-1:0] count;

  logic [SP_BITS-1:0]  sp_next;
  logic [CNT_BITS-1:0] count_next;
  logic [SP_BITS-1:0]  sp_inc;
  logic [SP_BITS-1:0]  sp_dec;
  logic                write_en;
  logic [SP_BITS-1:0]  write_ptr;
  logic                push_only;
  logic [CNT_BITS-1:0] lookup_count;

  // Pointer neighbours with wrap-around, DEPTH need not be a power of two
  assign sp_inc = (sp == SP_BITS'(DEPTH - 1)) ? '0 : sp + 1'b1;
  assign sp_dec = (sp == '0) ? SP_BITS'(DEPTH - 1) : sp - 1'b1;

  // Next-state of pointer and depth, plus where the pushed address lands
  always_comb begin
    sp_next    = sp;
    count_next = count;
    write_en   = 1'b0;
    write_ptr  = sp_inc;
    case ({push_en, pop_en})
      2'b10: begin
        // Plain push, the depth saturates and the oldest slot gets overwritten
        sp_next  = sp_inc;
        write_en = 1'b1;
        if (count != CNT_BITS'(DEPTH)) begin
          count_next = count + 1'b1;
        end
      end
      2'b01: begin
        // Pop on an empty stack is dropped
        if (count != '0) begin
          sp_next    = sp_dec;
          count_next = count - 1'b1;
        end
      end
      2'b11: begin
        if (count != '0) begin
          // Coroutine swap, the top is replaced in place and the depth holds
          write_en  = 1'b1;
          write_ptr = sp;
        end else begin
          // Nothing to pop, so only the push half has an effect
          sp_next    = sp_inc;
          count_next = count + 1'b1;
          write_en   = 1'b1;
        end
      end
      default: begin
        // Idle cycle, state holds
      end
    endcase
  end

  // A push-only cycle is visible to fetch at once, so a call followed
  // directly by its return still finds the right address
  // On a swap the lookup keeps the old top, which is the target being returned to
  assign push_only    = push_en && !pop_en;
  assign lookup_count = push_only ? count_next : count;
  assign ras_valid    = (lookup_count != '0);
  assign ras_target   = push_only ? push_addr : stack[sp];

  // Pointer and depth
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sp    <= '0;
      count <= '0;
    end else begin
      sp    <= sp_next;
      count <= count_next;
    end
  end

  // Stack storage
  always_ff @(posedge clk) begin
    if (write_en) begin
      stack[write_ptr] <= push_addr;
    end
  end

endmodule

// File: logic/rv_btb.sv
`timescale 1ns/10ps

`include "rv_pred_config.svh"

module rv_btb #(
  parameter int ENTRIES = `RV_BTB_ENTRIES
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`RV_XLEN-1:0]      fetch_pc,
  output logic                     hit,
  output rv_pred_pkg::cf_kind_e    kind,
  output logic [`RV_XLEN-1:0]      target,
  output logic                     predict_taken,
  input  rv_pred_pkg::btb_update_t update
);

  // PC bits [1:0] are always zero, the index starts at bit 2
  localparam int IDX_BITS = $clog2(ENTRIES);
  localparam int TAG_BITS = `RV_XLEN - IDX_BITS - 2;

  // Control state, cleared by reset
  logic [ENTRIES-1:0]    entry_valid;
  logic [1:0]            entry_ctr    [ENTRIES];
  // Payload, only meaningful where the valid bit is set
  logic [TAG_BITS-1:0]   entry_tag    [ENTRIES];
  rv_pred_pkg::cf_kind_e entry_kind   [ENTRIES];
  logic [`RV_XLEN-1:0]   entry_target [ENTRIES];

  logic [IDX_BITS-1:0]   lkp_idx;
  logic [TAG_BITS-1:0]   lkp_tag;
  logic [IDX_BITS-1:0]   upd_idx;
  logic [TAG_BITS-1:0]   upd_tag;
  logic                  upd_hit;
  logic                  upd_is_branch;
  logic                  alloc;
  logic                  train;
  logic [1:0]            ctr_next;

  // Fetch-side lookup, purely combinational
  assign lkp_idx = fetch_pc[IDX_BITS+1:2];
  assign lkp_tag = fetch_pc[`RV_XLEN-1:IDX_BITS+2];

  assign hit    = entry_valid[lkp_idx] && (entry_tag[lkp_idx] == lkp_tag);
  // A miss reports cf_none so the top level can treat kind alone as the decision
  assign kind   = hit ? entry_kind[lkp_idx] : rv_pred_pkg::cf_none;
  assign target = entry_target[lkp_idx];
  // Upper counter bit set means a counter of 2 or 3, which predicts taken
  assign predict_taken = hit && entry_ctr[lkp_idx][1];

  // Update side, split the resolved PC the same way as the lookup
  assign upd_idx       = update.pc[IDX_BITS+1:2];
  assign upd_tag       = update.pc[`RV_XLEN-1:IDX_BITS+2];
  assign upd_hit       = entry_valid[upd_idx] && (entry_tag[upd_idx] == upd_tag);
  assign upd_is_branch = (update.kind == rv_pred_pkg::cf_branch);

  // Jumps always (re)write their entry
  // A branch allocates only when it is taken and not already present
  assign alloc = update.valid &&
                 (!upd_is_branch || (update.taken && !upd_hit));

  // A branch that already owns its entry only moves the counter
  // A not-taken branch that misses falls through both and changes nothing
  assign train = update.valid && upd_is_branch && upd_hit;

  // Saturating up/down step of the 2-bit counter
  always_comb begin
    ctr_next = entry_ctr[upd_idx];
    if (update.taken) begin
      if (entry_ctr[upd_idx] != 2'b11) begin
        ctr_next = entry_ctr[upd_idx] + 2'b01;
      end
    end else begin
      if (entry_ctr[upd_idx] != 2'b00) begin
        ctr_next = entry_ctr[upd_idx] - 2'b01;
      end
    end
  end

  // Valid bits and counters
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      entry_valid <= '0;
      for (int i = 0; i < ENTRIES; i++) begin
        entry_ctr[i] <= 2'b00;
      end
    end else if (alloc) begin
      entry_valid[upd_idx] <= 1'b1;
      // New entries start weakly taken
      entry_ctr[upd_idx]   <= 2'b10;
    end else if (train) begin
      entry_ctr[upd_idx] <= ctr_next;
    end
  end

  // Tag, kind and target follow an allocation or a taken branch
  // that refreshes its target
  always_ff @(posedge clk) begin
    if (alloc || (train && update.taken)) begin
      entry_tag[upd_idx]    <= upd_tag;
      entry_kind[upd_idx]   <= update.kind;
      entry_target[upd_idx] <= update.target;
    end
  end

endmodule

// File: logic/rv_resolve_decode.sv
`timescale 1ns/10ps

`include "rv_pred_config.svh"

module rv_resolve_decode (
  input  rv_pred_pkg::resolve_t    resolve,
  output rv_pred_pkg::btb_update_t btb_update,
  output logic                     push_en,
  output logic [`RV_XLEN-1:0]      push_addr,
  output logic                     pop_en
);

  // Major opcodes of the three control-flow groups
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;

  logic [6:0]            opcode;
  logic [4:0]            rd;
  logic [4:0]            rs1;
  logic [2:0]            funct3;
  logic                  rd_link;
  logic                  rs1_link;
  rv_pred_pkg::cf_kind_e kind;

  // x1 and x5 are the link registers of the standard calling convention
  function automatic logic is_link(input logic [4:0] r);
    return (r == 5'd1) || (r == 5'd5);
  endfunction

  // Opcode and rd come out of the J view, they sit at the same place in both formats
  assign opcode = resolve.instr.j_view.opcode;
  assign rd     = resolve.instr.j_view.rd;
  // Only JALR needs rs1 and funct3, so those come out of the I view
  assign rs1    = resolve.instr.i_view.rs1;
  assign funct3 = resolve.instr.i_view.funct3;

  assign rd_link  = is_link(rd);
  assign rs1_link = is_link(rs1);

  // Classify the word by opcode and by the link-register hints
  always_comb begin
    kind = rv_pred_pkg::cf_none;
    if (opcode == OP_BRANCH) begin
      kind = rv_pred_pkg::cf_branch;
    end else if (opcode == OP_JAL) begin
      // A JAL that writes a link register is a call, anything else a plain jump
      kind = rd_link ? rv_pred_pkg::cf_call : rv_pred_pkg::cf_jump;
    end else if (opcode == OP_JALR && funct3 == 3'b000) begin
      if (rd_link && rs1_link) begin
        // Same link on both sides is a call, two different links swap coroutines
        kind = (rd == rs1) ? rv_pred_pkg::cf_call : rv_pred_pkg::cf_coret;
      end else if (rd_link) begin
        kind = rv_pred_pkg::cf_call;
      end else if (rs1_link) begin
        kind = rv_pred_pkg::cf_ret;
      end else begin
        kind = rv_pred_pkg::cf_jump;
      end
    end
  end

  // Every classified strobe goes to the BTB, which decides itself
  // whether a not-taken branch allocates or only trains
  assign btb_update.valid  = resolve.valid && (kind != rv_pred_pkg::cf_none);
  assign btb_update.pc     = resolve.pc;
  assign btb_update.target = resolve.target;
  assign btb_update.kind   = kind;
  // Jumps of every kind are always taken
  assign btb_update.taken  = (kind == rv_pred_pkg::cf_branch) ? resolve.taken : 1'b1;

  // Calls and coroutine swaps push the return address, returns and swaps pop
  assign push_en = resolve.valid &&
                   (kind == rv_pred_pkg::cf_call || kind == rv_pred_pkg::cf_coret);
  assign pop_en  = resolve.valid &&
                   (kind == rv_pred_pkg::cf_ret || kind == rv_pred_pkg::cf_coret);

  // No compressed instructions, so the return point is always four bytes on
  assign push_addr = resolve.pc + `RV_XLEN'(4);

endmodule

// File: logic/rv_pred_pkg.sv
`include "rv_pred_config.svh"

package rv_pred_pkg;

  // Control-flow class of a resolved instruction or a BTB entry
  // The value cf_none also marks a BTB miss on the lookup side
  typedef enum logic [2:0] {
    cf_none   = 3'd0,
    cf_branch = 3'd1,
    cf_jump   = 3'd2,
    cf_call   = 3'd3,
    cf_ret    = 3'd4,
    cf_coret  = 3'd5
  } cf_kind_e;

  // J-type layout, used for JAL and for the opcode and rd fields
  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } j_fmt_t;

  // I-type layout, used for JALR where rs1 and funct3 matter
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // One instruction word seen through both formats
  typedef union packed {
    j_fmt_t j_view;
    i_fmt_t i_view;
  } instr_word_u;

  // One resolved control-flow instruction from the back end
  // The valid bit is a single-cycle strobe
  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    instr_word_u         instr;
    logic [`RV_XLEN-1:0] target;
    logic                taken;
  } resolve_t;

  // Write command into the BTB, produced by the resolve decoder
  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] target;
    cf_kind_e            kind;
    logic                taken;
  } btb_update_t;

  // Answer handed back to fetch in the same cycle
  typedef struct packed {
    logic                taken;
    logic [`RV_XLEN-1:0] next_pc;
    cf_kind_e            kind;
  } fetch_pred_t;

endpackage

// File: include/rv_pred_config.svh
`ifndef RV_PRED_CONFIG_SVH
`define RV_PRED_CONFIG_SVH

// Build-wide sizes for the next-PC predictor

// Width of every address and instruction word the predictor handles
`define RV_XLEN 32

// Number of return addresses the RAS can hold before it wraps
// and overwrites the oldest entry
`define RV_RAS_DEPTH 8

// Number of BTB entries, must stay a power of two
// because the index is taken straight from the PC bits
`define RV_BTB_ENTRIES 16

`endif
